// ==== src.f ====
hdl/lcd_pkg.sv
hdl/lcd_item_if.sv
hdl/lcd_char_source.sv
hdl/lcd_cmd_fifo.sv
hdl/lcd_bus_driver.sv
hdl/lcd_char_display.sv
dv/tb_clock_gen.sv
dv/lcd_bus_monitor.sv
dv/tb_lcd_char_display.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_lcd_char_display -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_lcd_char_display.sv ====
`timescale 1ns/100ps

module tb_lcd_char_display
	import lcd_pkg::*;
();

	localparam int HOLD_SLOW = 2500; // longer than a write plus its settle
	localparam int HOLD_BURST = 3;
	localparam int HOLD_DRAIN = 20000; // a full fifo empties in this time

	logic clk;
	logic rst_n;
	logic reset_req;
	logic power_btn_n;
	lcd_code_t char_in;
	lcd_code_t lcd_data;
	logic lcd_en;
	logic lcd_rs;
	logic lcd_rw;
	logic lcd_power;
	logic exp_push;
	logic exp_clear;
	logic [8:0] exp_item;
	logic end_of_test;
	int pulses;
	int pending;
	int mismatches;
	int unexpected;
	int pin_errors;
	int leftover;

	// stimulus table, one entry per character or reset step
	lcd_code_t tbl_char [$];
	int tbl_hold [$];
	bit tbl_reset [$];

	logic [8:0] model_items [$]; // expected writes, {rs, data}
	int seg_len [$]; // writes per power-up segment

	int unsigned lcg_state = 32'd95723;
	longint limit_cycles = 0;
	int item_idx;
	int seg_idx;
	int pulse_base;
	int total_errors;

	tb_clock_gen u_clk_gen (
		.clk (clk),
		.rst_n (rst_n),
		.reset_req (reset_req)
	);

	lcd_char_display UUT (
		.clk (clk),
		.rst_n (rst_n),
		.char_in (char_in),
		.power_btn_n (power_btn_n),
		.lcd_data (lcd_data),
		.lcd_en (lcd_en),
		.lcd_rs (lcd_rs),
		.lcd_rw (lcd_rw),
		.lcd_power (lcd_power)
	);

	lcd_bus_monitor u_monitor (
		.clk (clk),
		.rst_n (rst_n),
		.power_btn_n (power_btn_n),
		.lcd_data (lcd_data),
		.lcd_en (lcd_en),
		.lcd_rs (lcd_rs),
		.lcd_rw (lcd_rw),
		.lcd_power (lcd_power),
		.exp_push (exp_push),
		.exp_item (exp_item),
		.exp_clear (exp_clear),
		.end_of_test (end_of_test),
		.pulses (pulses),
		.pending (pending),
		.mismatches (mismatches),
		.unexpected (unexpected),
		.pin_errors (pin_errors),
		.leftover (leftover)
	);

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16; // upper bits are the better ones
	endfunction

	function automatic lcd_code_t random_letter(input lcd_code_t prev);
		lcd_code_t c;
		c = lcd_code_t'(32'h41 + (lcg_next() % 32'd26)); // A..Z
		if (c == prev)
			c = (c == 8'h5A) ? 8'h41 : c + 8'h01; // no accidental repeats
		return c;
	endfunction

	task automatic add_entry(input lcd_code_t ch, input int hold);
		tbl_char.push_back(ch);
		tbl_hold.push_back(hold);
		tbl_reset.push_back(1'b0);
	endtask

	task automatic add_random(input int n, input int hold);
		for (int i = 0; i < n; i++)
			add_entry(random_letter(tbl_char[$]), hold);
	endtask

	task automatic build_table();
		add_entry("H", HOLD_SLOW);
		add_entry("i", HOLD_SLOW);
		add_entry("i", HOLD_SLOW); // repeat, no write
		add_entry("!", HOLD_SLOW);
		add_random(10, HOLD_SLOW);
		for (int i = 0; i < 8; i++)
			add_entry(lcd_code_t'(32'h30 + i), HOLD_BURST); // burst 0..7 through the fifo
		add_entry("7", HOLD_DRAIN); // repeat while the fifo drains
		add_random(24, HOLD_SLOW); // crosses column 32
		for (int i = 0; i < 4; i++)
			add_entry(lcd_code_t'(32'h61 + i), HOLD_BURST); // still queued at reset
		tbl_char.push_back(8'h00);
		tbl_hold.push_back(0);
		tbl_reset.push_back(1'b1);
		add_entry("O", HOLD_SLOW);
		add_entry("K", HOLD_SLOW);
		add_random(15, HOLD_SLOW); // line 2 again after reset
	endtask

	function automatic void model_write(input logic rs, input lcd_code_t code);
		model_items.push_back({rs, code});
	endfunction

	function automatic void model_init();
		model_write(1'b0, CMD_FUNC_SET);
		model_write(1'b0, CMD_CLEAR);
		model_write(1'b0, CMD_ENTRY);
		model_write(1'b0, CMD_LINE1);
	endfunction

	// expected writes: init, one per change, cursor command at each line end
	task automatic build_expected();
		lcd_code_t last;
		int col;
		int seg_start;
		last = 8'h00;
		col = 0;
		seg_start = 0;
		model_init();
		for (int i = 0; i < tbl_char.size(); i++) begin
			if (tbl_reset[i]) begin
				seg_len.push_back(model_items.size() - seg_start);
				seg_start = model_items.size();
				last = 8'h00; // source forgets its character
				col = 0;
				model_init();
			end else if (tbl_char[i] != last) begin
				model_write(1'b1, tbl_char[i]);
				last = tbl_char[i];
				col++;
				if (col == LINE_CHARS) begin
					model_write(1'b0, CMD_LINE2);
				end else if (col == 2 * LINE_CHARS) begin
					model_write(1'b0, CMD_LINE1);
					col = 0;
				end
			end
		end
		seg_len.push_back(model_items.size() - seg_start);
	endtask

	function automatic longint watchdog_cycles();
		longint n;
		n = longint'(seg_len.size()) * (longint'(DLY_POWER_UP) + 2 * longint'(DLY_LONG));
		n += longint'(model_items.size()) * (longint'(DLY_SHORT) + 10);
		foreach (tbl_hold[i])
			n += longint'(tbl_hold[i]);
		n += n / 10; // margin
		return n;
	endfunction

	task automatic next_drive_point();
		@(posedge clk);
		#10;
	endtask

	task automatic queue_expected(input logic [8:0] item);
		exp_item = item;
		exp_push = 1'b1; // monitor takes one per edge
		next_drive_point();
		exp_push = 1'b0;
	endtask

	task automatic load_segment(input int seg);
		for (int j = 0; j < seg_len[seg]; j++) begin
			queue_expected(model_items[item_idx]);
			item_idx++;
		end
	endtask

	task automatic power_up_display();
		power_btn_n = 1'b0; // pressed and held
		pulse_base = pulses;
		wait (pulses >= pulse_base + 4); // init writes out
		repeat (int'(DLY_SHORT) + 4) @(posedge clk); // settle of the last one
		#10;
	endtask

	task automatic reset_mid_stream();
		power_btn_n = 1'b1;
		char_in = 8'h00;
		reset_req = 1'b1;
		exp_clear = 1'b1;
		next_drive_point();
		exp_clear = 1'b0;
		repeat (2) next_drive_point(); // 3 cycles in reset
		reset_req = 1'b0;
	endtask

	initial begin
		reset_req = 1'b0;
		power_btn_n = 1'b1;
		char_in = 8'h00;
		exp_push = 1'b0;
		exp_clear = 1'b0;
		exp_item = '0;
		end_of_test = 1'b0;
		item_idx = 0;
		seg_idx = 0;
		pulse_base = 0;
		build_table();
		build_expected();
		limit_cycles = watchdog_cycles();
		wait (rst_n === 1'b1);
		next_drive_point();
		load_segment(seg_idx);
		power_up_display();
		for (int i = 0; i < tbl_char.size(); i++) begin
			if (tbl_reset[i]) begin
				reset_mid_stream();
				seg_idx++;
				load_segment(seg_idx);
				power_up_display();
			end else begin
				char_in = tbl_char[i];
				repeat (tbl_hold[i]) next_drive_point();
			end
		end
		wait (pending == 0);
		repeat (int'(DLY_SHORT) + 10) @(posedge clk); // room for stray pulses
		#10;
		end_of_test = 1'b1;
		repeat (2) @(posedge clk);
		total_errors = mismatches + unexpected + pin_errors + leftover;
		$display("%0d pulses, %0d mismatches, %0d unexpected, %0d pin errors, %0d left over",
			pulses, mismatches, unexpected, pin_errors, leftover);
		if (total_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles with %0d expected writes still pending",
			limit_cycles, pending);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== dv/lcd_bus_monitor.sv ====
`timescale 1ns/100ps

// watches the lcd pins, compares every enable pulse with the expected queue
module lcd_bus_monitor
	import lcd_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic power_btn_n,
	input lcd_code_t lcd_data,
	input logic lcd_en,
	input logic lcd_rs,
	input logic lcd_rw,
	input logic lcd_power,
	input logic exp_push, // one expected write per cycle
	input logic [8:0] exp_item, // {rs, data}
	input logic exp_clear, // drop what is still expected
	input logic end_of_test,
	output int pulses, // enable pulses seen
	output int pending, // expected writes not yet seen
	output int mismatches,
	output int unexpected,
	output int pin_errors, // rw, power and reset levels
	output int leftover
);

	logic [8:0] exp_q [$];
	logic [8:0] head;
	logic en_prev;
	logic end_seen;

	initial begin
		pulses = 0;
		pending = 0;
		mismatches = 0;
		unexpected = 0;
		pin_errors = 0;
		leftover = 0;
		en_prev = 1'b0;
		end_seen = 1'b0;
	end

	// values sampled at the clock edge, set one edge earlier by the DUT
	always @(posedge clk) begin
		if (lcd_rw !== 1'b0) begin
			pin_errors++;
			$display("FAILED at %0t: lcd_rw is %b, expected 0", $time, lcd_rw);
		end
		if (lcd_power !== !power_btn_n) begin
			pin_errors++;
			$display("FAILED at %0t: lcd_power is %b with power_btn_n %b",
				$time, lcd_power, power_btn_n);
		end
		if (!rst_n) begin
			// bus must be quiet in reset
			if (lcd_en !== 1'b0 || lcd_rs !== 1'b0 || lcd_data !== 8'h00) begin
				pin_errors++;
				$display("FAILED at %0t: bus not idle in reset, en=%b rs=%b data=0x%02h",
					$time, lcd_en, lcd_rs, lcd_data);
			end
			en_prev = 1'b0;
		end else begin
			if (lcd_en === 1'b1 && !en_prev) begin // rising edge of enable
				pulses++;
				if (exp_q.size() == 0) begin
					unexpected++;
					$display("enable pulse at %0t with rs=%b data=0x%02h but no write was expected",
						$time, lcd_rs, lcd_data);
				end else begin
					head = exp_q.pop_front();
					if ({lcd_rs, lcd_data} !== head) begin
						mismatches++;
						$display("FAILED at %0t: write %0d is rs=%b data=0x%02h, expected rs=%b data=0x%02h",
							$time, pulses, lcd_rs, lcd_data, head[8], head[7:0]);
					end
				end
			end
			en_prev = lcd_en;
		end
		if (exp_clear)
			exp_q.delete(); // writes lost with the fifo contents
		if (exp_push)
			exp_q.push_back(exp_item);
		if (end_of_test && !end_seen) begin
			end_seen = 1'b1;
			leftover = exp_q.size();
			if (leftover != 0)
				$display("%0d expected writes never appeared on the lcd bus", leftover);
		end
		pending = exp_q.size();
	end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n,
	input logic reset_req // extra reset pulse from the test sequence
);

	logic por_n; // power-on reset

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// power-on reset held for 3 cycles
	initial begin
		por_n = 1'b0;
		repeat (3) @(posedge clk);
		#10;
		por_n = 1'b1;
	end

	assign rst_n = por_n && !reset_req;

endmodule

// ==== hdl/lcd_char_display.sv ====
`timescale 1ns/100ps

module lcd_char_display
	import lcd_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input lcd_code_t char_in, // character to show
	input logic power_btn_n, // active low power button
	output lcd_code_t lcd_data,
	output logic lcd_en,
	output logic lcd_rs, // 0 command, 1 data
	output logic lcd_rw, // write only
	output logic lcd_power
);

	logic run; // init finished

	lcd_item_if push_if (); // source -> fifo
	lcd_item_if pop_if (); // fifo -> driver

	lcd_char_source u_source (
		.clk (clk),
		.rst_n (rst_n),
		.run (run),
		.char_in (char_in),
		.push (push_if.src)
	);

	lcd_cmd_fifo u_fifo (
		.clk (clk),
		.rst_n (rst_n),
		.wr (push_if.snk),
		.rd (pop_if.src)
	);

	lcd_bus_driver u_driver (
		.clk (clk),
		.rst_n (rst_n),
		.power_btn_n (power_btn_n),
		.cmd (pop_if.snk),
		.run (run),
		.lcd_data (lcd_data),
		.lcd_en (lcd_en),
		.lcd_rs (lcd_rs)
	);

	assign lcd_rw = 1'b0; // no bus reads
	assign lcd_power = !power_btn_n; // panel powered while button held

endmodule

// ==== hdl/lcd_bus_driver.sv ====
`timescale 1ns/100ps

module lcd_bus_driver
	import lcd_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic power_btn_n, // active low power button
	lcd_item_if.snk cmd,
	output logic run, // init done, source may start
	output lcd_code_t lcd_data,
	output logic lcd_en,
	output logic lcd_rs
);

	drv_state_t state;
	drv_state_t ret_state; // where SETTLE goes back to
	delay_cnt_t cnt; // shared by power-up wait and settle
	delay_cnt_t dly_target;
	logic cnt_done;
	lcd_code_t init_code;
	drv_state_t init_next;

	// pop strobe only in RUN with an item at the head
	assign cmd.ready = (state == RUN) && cmd.stb;

	// wait length for the current phase
	always_comb begin
		if (state == PWR_WAIT)
			dly_target = DLY_POWER_UP;
		else if (!lcd_rs && (lcd_data == CMD_CLEAR || lcd_data == CMD_HOME))
			dly_target = DLY_LONG; // slow commands
		else
			dly_target = DLY_SHORT;
	end

	assign cnt_done = (cnt == dly_target - delay_cnt_t'(1));

	// init sequence table
	always_comb begin
		case (state)
			INIT_FUNC: begin
				init_code = CMD_FUNC_SET;
				init_next = INIT_CLEAR;
			end
			INIT_CLEAR: begin
				init_code = CMD_CLEAR;
				init_next = INIT_ENTRY;
			end
			INIT_ENTRY: begin
				init_code = CMD_ENTRY;
				init_next = INIT_HOME;
			end
			INIT_HOME: begin
				init_code = CMD_LINE1; // cursor to first column of line 1
				init_next = RUN;
			end
			default: begin
				init_code = CMD_FUNC_SET;
				init_next = INIT_CLEAR;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			ret_state <= IDLE;
			cnt <= '0;
			run <= 1'b0;
			lcd_data <= '0;
			lcd_en <= 1'b0;
			lcd_rs <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (!power_btn_n) begin // button pressed
						cnt <= '0;
						state <= PWR_WAIT;
					end
				end
				PWR_WAIT: begin
					if (cnt_done) begin
						cnt <= '0;
						state <= INIT_FUNC;
					end else begin
						cnt <= cnt + delay_cnt_t'(1);
					end
				end
				INIT_FUNC, INIT_CLEAR, INIT_ENTRY, INIT_HOME: begin
					lcd_data <= init_code;
					lcd_rs <= 1'b0; // all init writes are commands
					lcd_en <= 1'b1;
					ret_state <= init_next;
					state <= PULSE;
				end
				RUN: begin
					run <= 1'b1;
					if (cmd.ready) begin // take the fifo head
						lcd_data <= cmd.code;
						lcd_rs <= cmd.rs;
						lcd_en <= 1'b1;
						ret_state <= RUN;
						state <= PULSE;
					end
				end
				PULSE: begin
					lcd_en <= 1'b0; // falling edge latches the write
					cnt <= '0;
					state <= SETTLE;
				end
				SETTLE: begin
					// data and rs stay put until the next pulse
					if (cnt_done) begin
						cnt <= '0;
						state <= ret_state;
					end else begin
						cnt <= cnt + delay_cnt_t'(1);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// enable is a single-cycle pulse
	a_en_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_en |=> !lcd_en)
		else $error("lcd_en high for more than one cycle");

	// pops come only between writes and after the source was let go
	a_pop_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		cmd.ready |-> (run && !lcd_en))
		else $error("pop before init done or while a write is on the bus");

endmodule

// ==== hdl/lcd_cmd_fifo.sv ====
`timescale 1ns/100ps

module lcd_cmd_fifo
	import lcd_pkg::*;
(
	input logic clk,
	input logic rst_n,
	lcd_item_if.snk wr,
	lcd_item_if.src rd
);

	logic rs_mem [FIFO_DEPTH];
	lcd_code_t code_mem [FIFO_DEPTH];

	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fifo_cnt_t fill; // occupancy
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full = (fill == fifo_cnt_t'(FIFO_DEPTH));
	assign empty = (fill == '0);

	// room if not full, or if the head leaves this same cycle
	assign wr.ready = !full || rd.ready;
	assign push = wr.stb && wr.ready;
	assign pop = rd.ready && !empty;

	// head shown combinationally, stb is the not-empty level
	assign rd.stb = !empty;
	assign rd.rs = rs_mem[rd_ptr];
	assign rd.code = code_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			rs_mem[wr_ptr] <= wr.rs;
			code_mem[wr_ptr] <= wr.code;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + fifo_ptr_t'(1); // depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + fifo_ptr_t'(1);
			case ({push, pop})
				2'b10: fill <= fill + fifo_cnt_t'(1);
				2'b01: fill <= fill - fifo_cnt_t'(1);
				default: fill <= fill; // none, or both at once
			endcase
		end
	end

	// a push into a full fifo is only legal when the driver pops alongside
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		(wr.stb && full) |-> rd.ready)
		else $error("push into full fifo");

	// driver pops only what is there
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		rd.ready |-> !empty)
		else $error("pop from empty fifo");

endmodule

// ==== hdl/lcd_char_source.sv ====
`timescale 1ns/100ps

module lcd_char_source
	import lcd_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic run, // init sequence done
	input lcd_code_t char_in,
	lcd_item_if.src push
);

	lcd_code_t last_char; // last character accepted into the fifo
	col_t col; // characters written since line 1 start
	logic line_pend; // cursor command owed before the next char
	logic new_char;
	col_t col_next;

	assign new_char = (char_in != last_char);
	assign col_next = col + col_t'(1); // wraps 31 -> 0

	// a pending line command goes first and the new char waits behind it
	assign push.stb = run && push.ready && (line_pend || new_char);
	assign push.rs = !line_pend;

	always_comb begin
		if (line_pend) begin
			// col sits at 16 after line 1 filled and at 0 after line 2
			if (col == col_t'(LINE_CHARS))
				push.code = CMD_LINE2;
			else
				push.code = CMD_LINE1;
		end else begin
			push.code = char_in; // whatever is on the input when taken
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_char <= '0;
			col <= '0;
			line_pend <= 1'b0;
		end else if (push.stb) begin
			if (line_pend) begin
				line_pend <= 1'b0; // command taken while the char is held back
			end else begin
				last_char <= char_in;
				col <= col_next;
				// end of a line reached
				line_pend <= (col_next == col_t'(LINE_CHARS)) || (col_next == '0);
			end
		end
	end

	// a line command is owed only at the end of a line
	a_pend_at_line_end: assert property (@(posedge clk) disable iff (!rst_n)
		line_pend |-> (col == col_t'(LINE_CHARS) || col == '0))
		else $error("line command pending away from a line end");

endmodule

// ==== hdl/lcd_item_if.sv ====
`timescale 1ns/100ps

// one display write item between two blocks
// push side: stb is the push strobe, ready means room
// pop side: stb is the item-available level, ready is the pop strobe
interface lcd_item_if
	import lcd_pkg::*;
();

	logic stb;
	logic rs; // 0 command, 1 data
	lcd_code_t code;
	logic ready;

	modport src (
		output stb,
		output rs,
		output code,
		input ready
	);

	modport snk (
		input stb,
		input rs,
		input code,
		output ready
	);

endinterface

// ==== hdl/lcd_pkg.sv ====
package lcd_pkg;

	// one byte on the lcd data bus, command or character
	typedef logic [7:0] lcd_code_t;
	typedef logic [19:0] delay_cnt_t; // wide enough for the 15 ms wait
	typedef logic [4:0] col_t; // cursor column over both lines, 0..31

	// delays in 50 MHz clock cycles
	localparam delay_cnt_t DLY_POWER_UP = 20'd750000; // 15 ms after power on
	localparam delay_cnt_t DLY_SHORT = 20'd2000; // 40 us, most commands and data
	localparam delay_cnt_t DLY_LONG = 20'd100000; // 2 ms, clear and home

	// hd44780 command set in use
	localparam lcd_code_t CMD_FUNC_SET = 8'h38; // 8 bit, 2 lines, 5x8 font
	localparam lcd_code_t CMD_CLEAR = 8'h01;
	localparam lcd_code_t CMD_ENTRY = 8'h06; // increment, no shift
	localparam lcd_code_t CMD_LINE1 = 8'h80; // ddram addr 0x00
	localparam lcd_code_t CMD_LINE2 = 8'hC0; // ddram addr 0x40
	localparam lcd_code_t CMD_HOME = 8'h02;

	localparam int LINE_CHARS = 16; // characters per display line

	// command fifo sizing
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	typedef logic [FIFO_AW-1:0] fifo_ptr_t;
	typedef logic [FIFO_AW:0] fifo_cnt_t; // holds 0..FIFO_DEPTH

	// bus driver states
	typedef enum logic [3:0] {
		IDLE,
		PWR_WAIT, // waiting after power button
		INIT_FUNC,
		INIT_CLEAR,
		INIT_ENTRY,
		INIT_HOME, // cursor to line 1 start
		RUN, // serving the fifo
		PULSE, // lcd_en high
		SETTLE // command execution time
	} drv_state_t;

endpackage
